/* design/rv_ex_pkg.sv */
`default_nettype none

package rv_ex_pkg;

    // Integer data width
    localparam int xlen = 32;

    // RV32I major opcodes handled by the execute stage
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } rv_opcode_e;

    // Low three bits follow funct3 and the top bit is funct7[5] for SUB and SRA
    typedef enum logic [3:0] {
        ALU_ADD    = 4'b0000,
        ALU_SLL    = 4'b0001,
        ALU_SLT    = 4'b0010,
        ALU_SLTU   = 4'b0011,
        ALU_XOR    = 4'b0100,
        ALU_SRL    = 4'b0101,
        ALU_OR     = 4'b0110,
        ALU_AND    = 4'b0111,
        ALU_SUB    = 4'b1000,
        ALU_PASS_B = 4'b1001,
        ALU_JALR   = 4'b1010,
        ALU_SRA    = 4'b1101
    } alu_op_e;

    // Branch funct3 maps straight onto this while the two unused codes carry jump and no-branch
    typedef enum logic [2:0] {
        BR_EQ     = 3'b000,
        BR_NE     = 3'b001,
        BR_ALWAYS = 3'b010,
        BR_NEVER  = 3'b011,
        BR_LT     = 3'b100,
        BR_GE     = 3'b101,
        BR_LTU    = 3'b110,
        BR_GEU    = 3'b111
    } br_op_e;

    // One decoded instruction
    typedef struct packed {
        logic [6:0]      opcode;
        logic [2:0]      funct3;
        logic [6:0]      funct7;
        logic [xlen-1:0] data1;
        logic [xlen-1:0] data2;
        logic [xlen-1:0] imm;
        logic [xlen-1:0] pc;
    } ex_req_t;

    typedef struct packed {
        logic [xlen-1:0] result;
        logic            taken;
        logic [xlen-1:0] link;
    } ex_resp_t;

endpackage

`default_nettype wire

/* design/ex_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_ctrl import rv_ex_pkg::*; (
    input  rv_opcode_e opcode,
    input  logic [2:0] funct3,
    input  logic [6:0] funct7,
    output logic       a_sel,   // 1 selects pc
    output logic       b_sel,   // 1 selects imm
    output br_op_e     br_op,
    output alu_op_e    alu_op
);

    logic is_reg;
    logic use_alt;

    assign is_reg = (opcode == OP_REG);

    // Only AUIPC, JAL and branches add to the pc
    assign a_sel = (opcode == OP_AUIPC) || (opcode == OP_JAL) || (opcode == OP_BRANCH);

    // Register-register is the only class reading data2 into the ALU
    assign b_sel = !is_reg;

    // funct7[5] picks SUB or SRA, but ADDI has no subtract form
    assign use_alt = funct7[5] && ((funct3 == 3'b101) || (funct3 == 3'b000 && is_reg));

    always_comb begin
        br_op  = BR_NEVER;
        alu_op = ALU_ADD;
        case (opcode)
            OP_LUI: begin
                alu_op = ALU_PASS_B;
            end
            OP_JAL: begin
                br_op = BR_ALWAYS;
            end
            OP_JALR: begin
                br_op  = BR_ALWAYS;
                alu_op = ALU_JALR;
            end
            OP_BRANCH: begin
                br_op = br_op_e'(funct3);
            end
            OP_REG, OP_IMM: begin
                alu_op = alu_op_e'({use_alt, funct3});
            end
            // AUIPC, loads and stores compute an address
            default: begin
                alu_op = ALU_ADD;
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/ex_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_alu import rv_ex_pkg::*; (
    input  alu_op_e         alu_op,
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    output logic [xlen-1:0] result
);

    logic [xlen-1:0] sum;
    logic [4:0]      shamt;
    logic            lt_signed;
    logic            lt_unsigned;

    assign sum         = a + b;
    assign shamt       = b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (alu_op)
            ALU_ADD:    result = sum;
            ALU_SUB:    result = a - b;
            ALU_SLL:    result = a << shamt;
            ALU_SLT:    result = {{(xlen-1){1'b0}}, lt_signed};
            ALU_SLTU:   result = {{(xlen-1){1'b0}}, lt_unsigned};
            ALU_XOR:    result = a ^ b;
            ALU_SRL:    result = a >> shamt;
            ALU_SRA:    result = $signed(a) >>> shamt;
            ALU_OR:     result = a | b;
            ALU_AND:    result = a & b;
            ALU_PASS_B: result = b;
            // Jump target is always halfword aligned
            ALU_JALR:   result = {sum[xlen-1:1], 1'b0};
            default:    result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* design/ex_branch.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_branch import rv_ex_pkg::*; (
    input  br_op_e          br_op,
    input  logic [xlen-1:0] data1,
    input  logic [xlen-1:0] data2,
    output logic            taken
);

    logic eq;
    logic lt;
    logic ltu;

    assign eq  = (data1 == data2);
    assign lt  = $signed(data1) < $signed(data2);
    assign ltu = data1 < data2;

    always_comb begin
        taken = 1'b0;
        case (br_op)
            BR_EQ:     taken = eq;
            BR_NE:     taken = !eq;
            BR_ALWAYS: taken = 1'b1;
            BR_NEVER:  taken = 1'b0;
            BR_LT:     taken = lt;
            BR_GE:     taken = !lt;
            BR_LTU:    taken = ltu;
            BR_GEU:    taken = !ltu;
            default:   taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* design/ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_stage import rv_ex_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  ex_req_t  in_req,
    output logic     out_valid,
    input  logic     out_ready,
    output ex_resp_t out_resp
);

    logic            a_sel;
    logic            b_sel;
    br_op_e          br_op;
    alu_op_e         alu_op;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_result;
    logic            taken;
    logic            accept;
    logic            valid_q;
    ex_resp_t        resp_d;
    ex_resp_t        resp_q;

    ex_ctrl u_ctrl (
        .opcode (rv_opcode_e'(in_req.opcode)),
        .funct3 (in_req.funct3),
        .funct7 (in_req.funct7),
        .a_sel  (a_sel),
        .b_sel  (b_sel),
        .br_op  (br_op),
        .alu_op (alu_op)
    );

    // Operand muxes
    assign op_a = a_sel ? in_req.pc  : in_req.data1;
    assign op_b = b_sel ? in_req.imm : in_req.data2;

    ex_alu u_alu (
        .alu_op (alu_op),
        .a      (op_a),
        .b      (op_b),
        .result (alu_result)
    );

    ex_branch u_branch (
        .br_op (br_op),
        .data1 (in_req.data1),
        .data2 (in_req.data2),
        .taken (taken)
    );

    assign resp_d.result = alu_result;
    assign resp_d.taken  = taken;
    assign resp_d.link   = in_req.pc + xlen'(4);

    // Slot frees up in the same cycle the held response leaves
    assign in_ready = !valid_q || out_ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            resp_q <= resp_d;
        end
    end

    assign out_valid = valid_q;
    assign out_resp  = resp_q;

    // Decode must resolve for every instruction that gets accepted
    a_alu_op_known: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> !$isunknown(alu_op));

    // Stalled response is held as is
    a_resp_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> $stable(out_resp));

    // No response is dropped without a transfer
    a_valid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid);

endmodule

`default_nettype wire

/* include/ex_ref_model.svh */
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

// Expected ALU result, worked out per instruction class
function automatic logic [31:0] calc_result(ex_req_t req);
    logic [31:0] b;
    logic [4:0]  sh;
    logic        alt;
    b   = (req.opcode == OP_REG) ? req.data2 : req.imm;
    sh  = b[4:0];
    alt = req.funct7[5];
    case (req.opcode)
        OP_LUI:                      return req.imm;
        OP_AUIPC, OP_JAL, OP_BRANCH: return req.pc + req.imm;
        OP_LOAD, OP_STORE:           return req.data1 + req.imm;
        OP_JALR:                     return (req.data1 + req.imm) & ~32'd1;
        OP_REG, OP_IMM: begin
            case (req.funct3)
                3'b000: return (alt && req.opcode == OP_REG) ? req.data1 - b : req.data1 + b;
                3'b001: return req.data1 << sh;
                3'b010: return {31'd0, $signed(req.data1) < $signed(b)};
                3'b011: return {31'd0, req.data1 < b};
                3'b100: return req.data1 ^ b;
                3'b101: return alt ? 32'($signed(req.data1) >>> sh) : req.data1 >> sh;
                3'b110: return req.data1 | b;
                default: return req.data1 & b;
            endcase
        end
        default: return req.data1 + req.imm;
    endcase
endfunction

// Expected taken flag
function automatic logic branch_taken(ex_req_t req);
    if (req.opcode == OP_JAL || req.opcode == OP_JALR) return 1'b1;
    if (req.opcode != OP_BRANCH) return 1'b0;
    case (req.funct3)
        3'b000:  return req.data1 == req.data2;
        3'b001:  return req.data1 != req.data2;
        3'b010:  return 1'b1;
        3'b100:  return $signed(req.data1) < $signed(req.data2);
        3'b101:  return $signed(req.data1) >= $signed(req.data2);
        3'b110:  return req.data1 < req.data2;
        3'b111:  return req.data1 >= req.data2;
        default: return 1'b0;
    endcase
endfunction

function automatic ex_resp_t expected_resp(ex_req_t req);
    ex_resp_t r;
    r.result = calc_result(req);
    r.taken  = branch_taken(req);
    r.link   = req.pc + 32'd4;
    return r;
endfunction

`endif

/* dv/tb_ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage import rv_ex_pkg::*; ();

    localparam int num_reqs   = 2000;
    localparam int max_cycles = num_reqs * 8;

    logic     clk;
    logic     rst_n;
    logic     in_valid;
    logic     in_ready;
    ex_req_t  in_req;
    logic     out_valid;
    logic     out_ready;
    ex_resp_t out_resp;

    logic [31:0] lfsr = 32'haf78;
    int          cycle_count = 0;
    int          sent = 0;
    int          received = 0;
    logic        in_taken = 1'b0;
    logic        stalled = 1'b0;
    ex_resp_t    held_resp;
    ex_resp_t    model_q[$];

    `include "ex_ref_model.svh"

    ex_stage u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_resp  (out_resp)
    );

    always #4 clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic rv_opcode_e pick_opcode(int idx);
        case (idx)
            0:       return OP_LUI;
            1:       return OP_AUIPC;
            2:       return OP_JAL;
            3:       return OP_JALR;
            4:       return OP_BRANCH;
            5:       return OP_LOAD;
            6:       return OP_STORE;
            7:       return OP_IMM;
            default: return OP_REG;
        endcase
    endfunction

    task automatic make_request(output ex_req_t req);
        req.opcode = pick_opcode(int'(rand_bits(4)) % 9);
        req.funct3 = 3'(rand_bits(3));
        req.funct7 = 7'(rand_bits(7));
        req.data1  = rand_bits(32);
        req.data2  = rand_bits(32);
        req.imm    = rand_bits(32);
        req.pc     = rand_bits(32);
        // Equal operands now and then, so BEQ and BNE both get exercised
        if (req.opcode == OP_BRANCH && rand_bits(2) == 0) begin
            req.data2 = req.data1;
        end
    endtask

    task automatic fail_run();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] time %0t: %s is %h, expected %h", $time, name, got, exp);
            fail_run();
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            $display("Simulation timed out after %0d cycles", cycle_count);
            fail_run();
        end
    end

    initial begin
        ex_req_t  next_req;
        ex_resp_t exp;
        clk       = 1'b0;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_req    = '0;
        out_ready = 1'b0;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;

        while (received < num_reqs) begin
            // Hold a pending request, otherwise decide on a new one
            if (!in_valid || in_taken) begin
                in_taken = 1'b0;
                if (sent < num_reqs && rand_bits(2) != 0) begin
                    make_request(next_req);
                    in_req   = next_req;
                    in_valid = 1'b1;
                end else begin
                    in_valid = 1'b0;
                end
            end
            out_ready = rand_bits(1) != 0;

            // Everything is settled halfway through the cycle
            @(negedge clk);
            if (stalled) begin
                check_value("out_valid", {31'd0, out_valid}, 32'd1);
                check_value("out_resp.result", out_resp.result, held_resp.result);
                check_value("out_resp.taken", {31'd0, out_resp.taken}, {31'd0, held_resp.taken});
                check_value("out_resp.link", out_resp.link, held_resp.link);
            end
            // One item in flight, so an outstanding entry means a full output register
            check_value("out_valid", {31'd0, out_valid}, {31'd0, (model_q.size() != 0)});
            check_value("in_ready", {31'd0, in_ready},
                        {31'd0, ((model_q.size() == 0) || out_ready)});
            if (out_valid && out_ready) begin
                if (model_q.size() == 0) begin
                    $display("A response came out with no request outstanding");
                    fail_run();
                end else begin
                    exp = model_q.pop_front();
                    check_value("out_resp.result", out_resp.result, exp.result);
                    check_value("out_resp.taken", {31'd0, out_resp.taken}, {31'd0, exp.taken});
                    check_value("out_resp.link", out_resp.link, exp.link);
                    received++;
                end
            end
            if (in_valid && in_ready) begin
                model_q.push_back(expected_resp(in_req));
                sent++;
                in_taken = 1'b1;
            end
            stalled   = out_valid && !out_ready;
            held_resp = out_resp;
            @(posedge clk);
            #1;
        end

        // Nothing more may come out once the model is drained
        in_valid  = 1'b0;
        out_ready = 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_value("out_valid", {31'd0, out_valid}, 32'd0);
        end

        if (model_q.size() == 0 && sent == num_reqs) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("Requests were left without a response");
            fail_run();
        end
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+include
design/rv_ex_pkg.sv
design/ex_ctrl.sv
design/ex_alu.sv
design/ex_branch.sv
design/ex_stage.sv
dv/tb_ex_stage.sv

/* Makefile */
TOP = tb_ex_stage
OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(OBJ) -f list.f

run: compile
	@out="$$(./$(OBJ)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf $(OBJ)
